// ==== filelist.f ====
src/mmu_pkg.sv
src/tlb_entry_store.sv
src/tlb_port_lookup.sv
src/tlb_access_merge.sv
src/tlb_top.sv
tests/tlb_tb.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tlb_tb
FILELIST = filelist.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/tlb_tb.sv ====
`timescale 1ns/1ns

module tlb_tb;

    localparam int tlb_entries    = 16;
    localparam int timeout_cycles = 50;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                req_valid;
    logic                req_ready;
    mmu_pkg::tlb_req_t   req;
    logic                resp_valid;
    logic                resp_ready;
    mmu_pkg::tlb_resp_t  resp;
    logic                fill_valid;
    logic                fill_ready;
    mmu_pkg::tlb_entry_t fill;

    // Reference copy of the table
    mmu_pkg::tlb_entry_t ref_tab [tlb_entries];
    int                  ref_victim;
    mmu_pkg::tlb_resp_t  exp_q;
    mmu_pkg::tlb_resp_t  prev_resp;
    int                  errors;
    int                  resp_count;
    int                  req_sent;

    tlb_top #(
        .tlb_entries (tlb_entries)
    ) tlb_top_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .fill       (fill)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(string name, string expv, string gotv);
        errors++;
        $display("CHECK FAILED at %0t ns: %s expected %s got %s", $time, name, expv, gotv);
    endtask

    task automatic report_problem(string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("Summary: %0d errors, %0d responses checked", errors, resp_count);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Index of the valid entry for a page, or -1
    function automatic int find_page(logic [19:0] vpn);
        int idx;
        idx = -1;
        for (int i = 0; i < tlb_entries; i++) begin
            if (ref_tab[i].valid && ref_tab[i].vpn == vpn) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic mmu_pkg::tlb_resp_t predict(mmu_pkg::tlb_req_t r);
        mmu_pkg::tlb_resp_t p;
        logic [31:0]        nl_addr;
        int                 cur_i;
        int                 nl_i;
        logic               allowed;
        nl_addr     = r.vaddr + 32'd64;
        cur_i       = find_page(r.vaddr[31:12]);
        nl_i        = find_page(nl_addr[31:12]);
        p.hit       = (cur_i >= 0);
        p.nl_hit    = (nl_i >= 0);
        p.paddr     = r.vaddr;
        p.nl_paddr  = nl_addr;
        p.pcd       = 1'b1;
        p.exception = 1'b1;
        if (p.hit) begin
            p.paddr = {ref_tab[cur_i].ppn, r.vaddr[11:0]};
            p.pcd   = !ref_tab[cur_i].cacheable;
            allowed = r.write ? ref_tab[cur_i].perm[mmu_pkg::perm_write]
                              : ref_tab[cur_i].perm[mmu_pkg::perm_read];
            p.exception = !allowed;
        end
        if (p.nl_hit) begin
            p.nl_paddr = {ref_tab[nl_i].ppn, nl_addr[11:0]};
        end
        p.cross_page = nl_addr[31:12] != r.vaddr[31:12];
        return p;
    endfunction

    function automatic logic [19:0] rand_ppn();
        return 20'($urandom);
    endfunction

    // Table follows accepted fills, flush clears it
    always @(posedge clk or posedge rst) begin : ref_update
        int hit_i;
        if (rst) begin
            for (int i = 0; i < tlb_entries; i++) begin
                ref_tab[i] <= '0;
            end
            ref_victim <= 0;
        end else if (flush) begin
            for (int i = 0; i < tlb_entries; i++) begin
                ref_tab[i].valid <= 1'b0;
            end
        end else if (fill_valid && fill_ready) begin
            hit_i = find_page(fill.vpn);
            if (hit_i >= 0) begin
                ref_tab[hit_i] <= fill;
            end else begin
                ref_tab[ref_victim] <= fill;
                ref_victim <= (ref_victim + 1) % tlb_entries;
            end
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_count <= 0;
        end else begin
            prev_resp <= resp;
            if (req_valid && req_ready) begin
                exp_q <= predict(req);
            end
            if (resp_valid && resp_ready) begin
                resp_count <= resp_count + 1;
            end
        end
    end

    assert property (@(posedge clk) rst |-> !resp_valid && req_ready && fill_ready)
        else report_problem("outputs not idle while reset is held");

    assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp.paddr == exp_q.paddr)
        else report_mismatch("resp.paddr", $sformatf("%h", $sampled(exp_q.paddr)),
            $sformatf("%h", $sampled(resp.paddr)));

    assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp.nl_paddr == exp_q.nl_paddr)
        else report_mismatch("resp.nl_paddr", $sformatf("%h", $sampled(exp_q.nl_paddr)),
            $sformatf("%h", $sampled(resp.nl_paddr)));

    // Order is hit, nl_hit, pcd, exception, cross_page
    assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> {resp.hit, resp.nl_hit, resp.pcd, resp.exception, resp.cross_page}
            == {exp_q.hit, exp_q.nl_hit, exp_q.pcd, exp_q.exception, exp_q.cross_page})
        else report_mismatch("resp flags",
            $sformatf("%b", $sampled({exp_q.hit, exp_q.nl_hit, exp_q.pcd,
                exp_q.exception, exp_q.cross_page})),
            $sformatf("%b", $sampled({resp.hit, resp.nl_hit, resp.pcd,
                resp.exception, resp.cross_page})));

    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp == prev_resp)
        else report_mismatch("resp (stalled)", $sformatf("%h", $sampled(prev_resp)),
            $sformatf("%h", $sampled(resp)));

    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid)
        else report_mismatch("resp_valid (stalled)", "1", "0");

    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |-> !req_ready)
        else report_mismatch("req_ready", "0", "1");

    assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |-> !fill_ready)
        else report_mismatch("fill_ready", "0", "1");

    assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> resp_valid)
        else report_mismatch("resp_valid", "1", "0");

    // Hold a request until the DUT takes it
    task automatic send_req(logic [31:0] vaddr, logic write);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req.vaddr = vaddr;
        req.write = write;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > timeout_cycles) begin
                report_problem("request was never accepted");
                finish_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req_sent++;
    endtask

    task automatic send_fill(logic [19:0] vpn, logic [19:0] ppn, logic cacheable,
                             logic [3:0] perm);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        fill_valid     = 1'b1;
        fill.valid     = 1'b1;
        fill.vpn       = vpn;
        fill.ppn       = ppn;
        fill.cacheable = cacheable;
        fill.perm      = perm;
        @(negedge clk);
        while (!fill_ready) begin
            waited++;
            if (waited > timeout_cycles) begin
                report_problem("fill was never accepted");
                finish_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        fill_valid = 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (resp_valid) begin
            waited++;
            if (waited > timeout_cycles) begin
                report_problem("response was never drained");
                finish_run();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic [19:0] pages [6];
        logic [31:0] addr;
        errors     = 0;
        req_sent   = 0;
        void'($urandom(32'hd0a36aff));
        rst        = 1'b1;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        fill_valid = 1'b0;
        fill       = '0;
        pages      = '{20'h00010, 20'h00011, 20'h00012, 20'h00013, 20'h00020, 20'h55555};
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Mixed rights: rw, read only, write only uncached, read+exec, all
        send_fill(20'h00010, rand_ppn(), 1'b1, 4'b0011);
        send_fill(20'h00011, rand_ppn(), 1'b1, 4'b0001);
        send_fill(20'h00012, rand_ppn(), 1'b0, 4'b0010);
        send_fill(20'h00013, rand_ppn(), 1'b1, 4'b0101);
        send_fill(20'h00020, rand_ppn(), 1'b1, 4'b1111);

        // Reads and writes, last two land in the final line of the page
        for (int p = 0; p < 6; p++) begin
            for (int k = 0; k < 4; k++) begin
                addr = {pages[p], 12'($urandom)};
                if (k >= 2) begin
                    addr[11:6] = 6'h3f;
                end
                send_req(addr, k[0]);
            end
        end

        // Random traffic against a consumer that stalls at random
        fork
            begin
                for (int n = 0; n < 30; n++) begin
                    addr = {20'h00010 + 20'($urandom % 5), 12'($urandom)};
                    send_req(addr, 1'($urandom));
                end
            end
            begin
                repeat (60) begin
                    @(posedge clk);
                    #1;
                    resp_ready = 1'($urandom);
                end
                resp_ready = 1'b1;
            end
        join

        // Second request waits behind a held response
        wait_idle();
        @(posedge clk);
        #1;
        resp_ready = 1'b0;
        send_req(32'h0001_0abc, 1'b0);
        fork
            send_req(32'h0001_1ff0, 1'b1);
            begin
                repeat (6) @(posedge clk);
                #1;
                resp_ready = 1'b1;
            end
        join

        // Fill offered in the same cycle as a request goes in afterwards
        fork
            send_req(32'h0001_4100, 1'b0);
            send_fill(20'h00014, rand_ppn(), 1'b1, 4'b0011);
        join
        send_req(32'h0001_4100, 1'b0);

        // Refill of a known page, now uncached and writable
        send_fill(20'h00011, rand_ppn(), 1'b0, 4'b0011);
        send_req(32'h0001_1234, 1'b1);

        // Enough new pages to wrap the victim pointer
        for (int i = 0; i < 14; i++) begin
            send_fill(20'h00100 + 20'(i), rand_ppn(), 1'b1, 4'b0011);
        end
        send_req(32'h0010_0040, 1'b0);
        send_req(32'h0010_dfe0, 1'b1);
        send_req(32'h0001_0010, 1'b0);
        send_req(32'h0001_2ff8, 1'b1);

        pulse_flush();
        for (int p = 0; p < 6; p++) begin
            send_req({pages[p], 12'h800}, 1'b0);
        end

        wait_idle();
        if (resp_count != req_sent) begin
            report_mismatch("resp_count", $sformatf("%0d", req_sent),
                $sformatf("%0d", resp_count));
        end
        finish_run();
    end

endmodule

// ==== src/tlb_top.sv ====
`timescale 1ns/1ns

module tlb_top #(
    parameter int tlb_entries    = 16,
    parameter int vaddr_w        = 32,
    parameter int page_offset_w  = 12,
    parameter int nl_line_offset = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    // Request channel
    input  logic                req_valid,
    output logic                req_ready,
    input  mmu_pkg::tlb_req_t   req,
    // Response channel
    output logic                resp_valid,
    input  logic                resp_ready,
    output mmu_pkg::tlb_resp_t  resp,
    // Page walker fills
    input  logic                fill_valid,
    output logic                fill_ready,
    input  mmu_pkg::tlb_entry_t fill
);

    mmu_pkg::tlb_entry_t [tlb_entries-1:0] entries;
    mmu_pkg::tlb_port_result_t             cur_result;
    mmu_pkg::tlb_port_result_t             nl_result;
    logic [3:0]                            cur_perm;
    logic                                  cur_cacheable;
    logic                                  req_fire;

    assign req_fire = req_valid && req_ready;

    tlb_entry_store #(
        .tlb_entries (tlb_entries)
    ) store_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .fill       (fill),
        .req_fire   (req_fire),
        .entries    (entries)
    );

    // Current cache line
    tlb_port_lookup #(
        .tlb_entries   (tlb_entries),
        .vaddr_w       (vaddr_w),
        .page_offset_w (page_offset_w),
        .line_offset   (0)
    ) cur_lookup (
        .entries   (entries),
        .vaddr     (req.vaddr),
        .result    (cur_result),
        .perm      (cur_perm),
        .cacheable (cur_cacheable)
    );

    // Next sequential line, no permission check on this side
    tlb_port_lookup #(
        .tlb_entries   (tlb_entries),
        .vaddr_w       (vaddr_w),
        .page_offset_w (page_offset_w),
        .line_offset   (nl_line_offset)
    ) nl_lookup (
        .entries   (entries),
        .vaddr     (req.vaddr),
        .result    (nl_result),
        .perm      (),
        .cacheable ()
    );

    tlb_access_merge #(
        .vaddr_w       (vaddr_w),
        .page_offset_w (page_offset_w),
        .line_offset   (nl_line_offset)
    ) merge_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .cur           (cur_result),
        .nl            (nl_result),
        .cur_perm      (cur_perm),
        .cur_cacheable (cur_cacheable),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp)
    );

endmodule

// ==== src/tlb_access_merge.sv ====
`timescale 1ns/1ns

module tlb_access_merge #(
    parameter int vaddr_w       = 32,
    parameter int page_offset_w = 12,
    parameter int line_offset   = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  mmu_pkg::tlb_req_t         req,
    input  mmu_pkg::tlb_port_result_t cur,
    input  mmu_pkg::tlb_port_result_t nl,
    input  logic [3:0]                cur_perm,
    input  logic                      cur_cacheable,
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output mmu_pkg::tlb_resp_t        resp
);

    logic                   req_fire;
    logic [vaddr_w-1:0]     nl_vaddr;
    logic                   perm_ok;
    logic                   resp_valid_q;
    mmu_pkg::tlb_resp_t     resp_d;
    mmu_pkg::tlb_resp_t     resp_q;

    // Accept when the slot is empty or drains this cycle
    assign req_ready = !resp_valid_q || resp_ready;
    assign req_fire  = req_valid && req_ready;

    assign nl_vaddr = req.vaddr + vaddr_w'(line_offset);

    // Only read and write rights are checked
    always_comb begin
        if (req.write) begin
            perm_ok = cur_perm[mmu_pkg::perm_write];
        end else begin
            perm_ok = cur_perm[mmu_pkg::perm_read];
        end
    end

    always_comb begin
        resp_d.paddr      = cur.paddr;
        resp_d.hit        = cur.hit;
        resp_d.nl_paddr   = nl.paddr;
        resp_d.nl_hit     = nl.hit;
        resp_d.pcd        = !cur.hit || !cur_cacheable;
        // Miss counts as a page fault
        resp_d.exception  = !cur.hit || !perm_ok;
        resp_d.cross_page = nl_vaddr[vaddr_w-1:page_offset_w]
            != req.vaddr[vaddr_w-1:page_offset_w];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_q <= 1'b0;
        end else if (req_fire) begin
            resp_valid_q <= 1'b1;
        end else if (resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    // Response payload, loaded on accept only
    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp_q <= resp_d;
        end
    end

    assign resp_valid = resp_valid_q;
    assign resp       = resp_q;

    // Stalled response holds until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// ==== src/tlb_port_lookup.sv ====
`timescale 1ns/1ns

module tlb_port_lookup #(
    parameter int tlb_entries   = 16,
    parameter int vaddr_w       = 32,
    parameter int page_offset_w = 12,
    parameter int line_offset   = 0
) (
    input  mmu_pkg::tlb_entry_t [tlb_entries-1:0] entries,
    input  logic [vaddr_w-1:0]                    vaddr,
    output mmu_pkg::tlb_port_result_t             result,
    output logic [3:0]                            perm,
    output logic                                  cacheable
);

    logic [vaddr_w-1:0]              addr;
    logic [tlb_entries-1:0]          match;
    logic [mmu_pkg::ppn_w-1:0]       ppn_sel;
    logic [mmu_pkg::perm_w-1:0]      perm_sel;
    logic                            cacheable_sel;

    // Address this unit translates
    assign addr = vaddr + vaddr_w'(line_offset);

    // Fully associative tag compare
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = entries[i].valid
                && (entries[i].vpn == addr[vaddr_w-1:page_offset_w]);
        end
    end

    // AND-OR select, match is one-hot
    always_comb begin
        ppn_sel       = '0;
        perm_sel      = '0;
        cacheable_sel = 1'b0;
        for (int i = 0; i < tlb_entries; i++) begin
            ppn_sel       = ppn_sel | ({mmu_pkg::ppn_w{match[i]}} & entries[i].ppn);
            perm_sel      = perm_sel | ({mmu_pkg::perm_w{match[i]}} & entries[i].perm);
            cacheable_sel = cacheable_sel | (match[i] & entries[i].cacheable);
        end
    end

    // On a miss the virtual address goes through untouched
    always_comb begin
        result.hit = |match;
        if (result.hit) begin
            result.paddr = {ppn_sel, addr[page_offset_w-1:0]};
        end else begin
            result.paddr = addr;
        end
    end

    assign perm      = perm_sel;
    assign cacheable = cacheable_sel;

    // Store never holds two valid entries for one page
    always_comb begin
        assert ($onehot0(match));
    end

endmodule

// ==== src/tlb_entry_store.sv ====
`timescale 1ns/1ns

module tlb_entry_store #(
    parameter int tlb_entries = 16
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     flush,
    input  logic                                     fill_valid,
    output logic                                     fill_ready,
    input  mmu_pkg::tlb_entry_t                      fill,
    input  logic                                     req_fire,
    output mmu_pkg::tlb_entry_t [tlb_entries-1:0]    entries
);

    localparam int idx_w = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

    logic [tlb_entries-1:0]                valid_q;
    mmu_pkg::tlb_entry_t [tlb_entries-1:0] entry_q;
    logic [idx_w-1:0]                      victim_q;
    logic [tlb_entries-1:0]                fill_match;
    logic                                  match_any;
    logic [idx_w-1:0]                      match_idx;
    logic [idx_w-1:0]                      wr_idx;
    logic                                  fill_fire;

    // Lookups win, the walker retries next cycle
    assign fill_ready = !req_fire;
    assign fill_fire  = fill_valid && fill_ready;

    // Existing translation for the same page gets overwritten
    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            fill_match[i] = valid_q[i] && (entry_q[i].vpn == fill.vpn);
            if (fill_match[i]) begin
                match_any = 1'b1;
                match_idx = idx_w'(i);
            end
        end
    end

    assign wr_idx = match_any ? match_idx : victim_q;

    // Valid bits and victim pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill_fire) begin
            valid_q[wr_idx] <= fill.valid;
            // Round robin only moves when a new slot was taken
            if (!match_any) begin
                if (victim_q == idx_w'(tlb_entries - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (fill_fire && !flush) begin
            entry_q[wr_idx] <= fill;
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            entries[i]       = entry_q[i];
            entries[i].valid = valid_q[i];
        end
    end

    // A cycle that carries a lookup leaves the table alone
    assert property (@(posedge clk) disable iff (rst)
        req_fire && !flush |=> $stable(valid_q) && $stable(entry_q) && $stable(victim_q));

endmodule

// ==== src/mmu_pkg.sv ====
package mmu_pkg;

    // Field widths for a 32-bit address with 4 KiB pages
    localparam int vpn_w  = 20;
    localparam int ppn_w  = 20;
    localparam int perm_w = 4;

    // Bit positions inside the permission field
    localparam int perm_read  = 0;
    localparam int perm_write = 1;
    localparam int perm_exec  = 2;
    localparam int perm_user  = 3;

    // One translation, as written by the page walker
    typedef struct packed {
        logic              valid;
        logic [vpn_w-1:0]  vpn;
        logic [ppn_w-1:0]  ppn;
        logic              cacheable;
        logic [perm_w-1:0] perm;
    } tlb_entry_t;

    // Lookup request from the fetch front end
    typedef struct packed {
        logic [31:0] vaddr;
        // High for a store access
        logic        write;
    } tlb_req_t;

    // Translation of one address stream
    typedef struct packed {
        logic        hit;
        logic [31:0] paddr;
    } tlb_port_result_t;

    // Registered response for one accepted request
    typedef struct packed {
        // Current line
        logic [31:0] paddr;
        logic        hit;
        // Sequential next line for the prefetcher
        logic [31:0] nl_paddr;
        logic        nl_hit;
        // Uncacheable access, also set on a miss
        logic        pcd;
        // Page fault or permission violation on the current line
        logic        exception;
        // Next line sits on another page
        logic        cross_page;
    } tlb_resp_t;

endpackage
